/* source/pong_shell_pkg.sv */
//////////////////////////////////////////////////////////////////////
// pong shell package
// shared widths, bridge setting addresses, pad bit positions and
// the audio clocking and framing constants
//////////////////////////////////////////////////////////////////////

`default_nettype none

package pong_shell_pkg;

  typedef logic [31:0] bridge_word_t;
  typedef logic [15:0] key_word_t;
  typedef logic [23:0] rgb_t;

  // bridge addresses of the game settings
  localparam bridge_word_t addr_score_stop    = 32'h0000_0000;
  localparam bridge_word_t addr_p2_pad_only   = 32'h0000_0008;
  localparam bridge_word_t addr_coin_hold     = 32'h0000_000C;
  localparam bridge_word_t addr_double_paddle = 32'h0000_0014;
  localparam bridge_word_t addr_training      = 32'h0000_0018;

  // controller key bitmap positions
  localparam int key_up        = 0;
  localparam int key_down      = 1;
  localparam int key_left_face = 5;
  localparam int key_x_face    = 6;
  localparam int key_fine_l    = 8;
  localparam int key_fine_r    = 9;
  localparam int key_start     = 15;

  //////////////////////////////////////////////////////////////////////
  // audio

  // 12.288 MHz from 74.25 MHz, two mclk toggles per period
  localparam logic [21:0] mclk_step = 22'd245760;
  localparam logic [21:0] mclk_wrap = 22'd742500;

  localparam int sclk_div_bits   = 2;
  localparam int half_frame_bits = 32;
  localparam int active_bits     = 16;

  localparam logic [15:0] sound_level = 16'h7000;

  // one stereo sample pair, shifted out as a single word
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] left;
      logic [15:0] right;
    } ch;
  } audio_frame_u;

endpackage

`default_nettype wire

/* source/bridge_settings.sv */
//////////////////////////////////////////////////////////////////////
// bridge settings
// captures bridge writes into the five game setting levels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module bridge_settings (
  input  logic                        clk_74a,
  input  logic                        arst_n,
  input  logic                        bridge_wr,
  input  pong_shell_pkg::bridge_word_t bridge_addr,
  input  pong_shell_pkg::bridge_word_t bridge_wr_data,
  output logic                        score_stop_at_15,
  output logic                        disable_p2_on_pad_1,
  output logic                        prevent_coin_reset,
  output logic                        double_paddle_height,
  output logic                        training_mode
);

  import pong_shell_pkg::*;

  // coin reset protection defaults on, all else off
  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      score_stop_at_15     <= 1'b0;
      disable_p2_on_pad_1  <= 1'b0;
      prevent_coin_reset   <= 1'b1;
      double_paddle_height <= 1'b0;
      training_mode        <= 1'b0;
    end
    else if (bridge_wr)
    begin
      // only data bit 0 carries the setting
      case (bridge_addr)
        addr_score_stop:    score_stop_at_15     <= bridge_wr_data[0];
        addr_p2_pad_only:   disable_p2_on_pad_1  <= bridge_wr_data[0];
        addr_coin_hold:     prevent_coin_reset   <= bridge_wr_data[0];
        addr_double_paddle: double_paddle_height <= bridge_wr_data[0];
        addr_training:      training_mode        <= bridge_wr_data[0];
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/player_input_map.sv */
//////////////////////////////////////////////////////////////////////
// player input map
// routes pad buttons to both paddles and turns start into a coin pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module player_input_map (
  input  logic                      clk_74a,
  input  logic                      arst_n,
  input  pong_shell_pkg::key_word_t cont1_key,
  input  pong_shell_pkg::key_word_t cont2_key,
  input  logic                      disable_p2_on_pad_1,
  output logic                      p1_up,
  output logic                      p1_down,
  output logic                      p1_fine,
  output logic                      p2_up,
  output logic                      p2_down,
  output logic                      p2_fine,
  output logic                      coin_insert
);

  import pong_shell_pkg::*;

  logic start_prev;

  // player 1 always on pad 1
  assign p1_up   = cont1_key[key_up];
  assign p1_down = cont1_key[key_down];
  assign p1_fine = cont1_key[key_fine_l];

  // player 2 can share pad 1 via X, B and R1
  assign p2_up   = disable_p2_on_pad_1 ? cont2_key[key_up] :
                   (cont2_key[key_up] | cont1_key[key_x_face]);
  assign p2_down = disable_p2_on_pad_1 ? cont2_key[key_down] :
                   (cont2_key[key_down] | cont1_key[key_left_face]);
  assign p2_fine = disable_p2_on_pad_1 ? cont2_key[key_fine_l] :
                   (cont2_key[key_fine_l] | cont1_key[key_fine_r]);

  // rising edge of start, so a held button inserts one coin
  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      start_prev  <= 1'b0;
      coin_insert <= 1'b0;
    end
    else
    begin
      start_prev  <= cont1_key[key_start];
      coin_insert <= cont1_key[key_start] & ~start_prev;
    end
  end

endmodule

`default_nettype wire

/* source/video_cleanup.sv */
//////////////////////////////////////////////////////////////////////
// video cleanup
// shapes sync into single-cycle pulses and blanks colour outside
// display enable, as the scaler expects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module video_cleanup (
  input  logic                 clk_74a,
  input  logic                 arst_n,
  input  logic                 core_de,
  input  logic                 core_hs,
  input  logic                 core_vs,
  input  pong_shell_pkg::rgb_t core_rgb,
  output logic                 video_de,
  output logic                 video_hs,
  output logic                 video_vs,
  output pong_shell_pkg::rgb_t video_rgb
);

  import pong_shell_pkg::*;

  logic de_d;
  logic hs_d1;
  logic hs_d2;
  logic vs_d1;
  logic vs_d2;
  rgb_t rgb_d;

  // colour pipe stage, blanked at the output stage
  always_ff @(posedge clk_74a)
  begin
    rgb_d <= core_rgb;
  end

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      de_d      <= 1'b0;
      hs_d1     <= 1'b0;
      hs_d2     <= 1'b0;
      vs_d1     <= 1'b0;
      vs_d2     <= 1'b0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
    end
    else
    begin
      de_d      <= core_de;
      video_de  <= de_d;
      video_rgb <= de_d ? rgb_d : '0;
      // falling sync edge, lined up with the de latency
      hs_d1    <= core_hs;
      hs_d2    <= hs_d1;
      vs_d1    <= core_vs;
      vs_d2    <= vs_d1;
      video_hs <= hs_d2 & ~hs_d1;
      video_vs <= vs_d2 & ~vs_d1;
    end
  end

endmodule

`default_nettype wire

/* source/audio_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// audio clock generator
// fractional accumulator for a 12.288 MHz mclk, mclk/4 bit clock and
// a strobe on every falling bit clock edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module audio_clock_gen (
  input  logic clk_74a,
  input  logic arst_n,
  output logic audio_mclk,
  output logic audio_sclk,
  output logic sclk_fall
);

  import pong_shell_pkg::*;

  logic [21:0]              accum;
  logic [sclk_div_bits-1:0] sclk_div;
  logic                     mclk_tick;
  logic                     mclk_rise;

  assign mclk_tick  = (accum >= mclk_wrap);
  assign mclk_rise  = mclk_tick & ~audio_mclk;
  assign audio_sclk = sclk_div[sclk_div_bits-1];

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      accum      <= '0;
      audio_mclk <= 1'b0;
      sclk_div   <= '0;
      sclk_fall  <= 1'b0;
    end
    else
    begin
      if (mclk_tick)
      begin
        accum      <= accum - mclk_wrap + mclk_step;
        audio_mclk <= ~audio_mclk;
      end
      else
      begin
        accum <= accum + mclk_step;
      end

      // divider advances on mclk rising toggles only
      if (mclk_rise)
      begin
        sclk_div <= sclk_div + 1'b1;
      end
      // all ones about to wrap means sclk drops next cycle
      sclk_fall <= mclk_rise & (&sclk_div);
    end
  end

endmodule

`default_nettype wire

/* source/i2s_serializer.sv */
//////////////////////////////////////////////////////////////////////
// i2s serializer
// frames the square wave sample and shifts 16 of 32 bits per channel
// out msb first, stepping on falling bit clock edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module i2s_serializer (
  input  logic clk_74a,
  input  logic arst_n,
  input  logic sclk_fall,
  input  logic core_sound,
  output logic audio_lrck,
  output logic audio_dac
);

  import pong_shell_pkg::*;

  audio_frame_u                        frame;
  audio_frame_u                        shift;
  logic [$clog2(half_frame_bits)-1:0]  bit_cnt;

  // same level on both channels
  always_comb
  begin
    frame.ch.left  = core_sound ? sound_level : '0;
    frame.ch.right = core_sound ? sound_level : '0;
  end

  always_ff @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      shift.word <= '0;
      bit_cnt    <= '0;
      audio_lrck <= 1'b0;
      audio_dac  <= 1'b0;
    end
    else if (sclk_fall)
    begin
      audio_dac <= shift.word[31];
      bit_cnt   <= bit_cnt + 1'b1;

      if (bit_cnt == half_frame_bits - 1)
      begin
        // channel switch, new sample pair ahead of the left half
        audio_lrck <= ~audio_lrck;
        if (!audio_lrck)
        begin
          shift.word <= frame.word;
        end
      end
      else if (bit_cnt < active_bits)
      begin
        // zeros fill the remaining bits of the half
        shift.word <= {shift.word[30:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* source/pong_shell_top.sv */
//////////////////////////////////////////////////////////////////////
// pong shell top
// glue between the paddle game core, the bridge, the pads, the
// scaler and the i2s codec
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pong_shell_top (
  input  logic                         clk_74a,
  input  logic                         arst_n,
  input  logic                         bridge_wr,
  input  pong_shell_pkg::bridge_word_t bridge_addr,
  input  pong_shell_pkg::bridge_word_t bridge_wr_data,
  input  pong_shell_pkg::key_word_t    cont1_key,
  input  pong_shell_pkg::key_word_t    cont2_key,
  input  logic                         core_de,
  input  logic                         core_hs,
  input  logic                         core_vs,
  input  pong_shell_pkg::rgb_t         core_rgb,
  input  logic                         core_sound,
  output logic                         score_stop_at_15,
  output logic                         disable_p2_on_pad_1,
  output logic                         prevent_coin_reset,
  output logic                         double_paddle_height,
  output logic                         training_mode,
  output logic                         p1_up,
  output logic                         p1_down,
  output logic                         p1_fine,
  output logic                         p2_up,
  output logic                         p2_down,
  output logic                         p2_fine,
  output logic                         coin_insert,
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs,
  output pong_shell_pkg::rgb_t         video_rgb,
  output logic                         audio_mclk,
  output logic                         audio_sclk,
  output logic                         audio_lrck,
  output logic                         audio_dac
);

  logic sclk_fall;

  bridge_settings i_bridge_settings (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .bridge_wr(bridge_wr), .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
    .score_stop_at_15(score_stop_at_15), .disable_p2_on_pad_1(disable_p2_on_pad_1),
    .prevent_coin_reset(prevent_coin_reset), .double_paddle_height(double_paddle_height),
    .training_mode(training_mode)
  );

  player_input_map i_player_input_map (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .cont1_key(cont1_key), .cont2_key(cont2_key),
    .disable_p2_on_pad_1(disable_p2_on_pad_1),
    .p1_up(p1_up), .p1_down(p1_down), .p1_fine(p1_fine),
    .p2_up(p2_up), .p2_down(p2_down), .p2_fine(p2_fine),
    .coin_insert(coin_insert)
  );

  video_cleanup i_video_cleanup (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .core_de(core_de), .core_hs(core_hs), .core_vs(core_vs), .core_rgb(core_rgb),
    .video_de(video_de), .video_hs(video_hs), .video_vs(video_vs), .video_rgb(video_rgb)
  );

  //////////////////////////////////////////////////////////////////////
  // audio path, clocks then framing and shifting

  audio_clock_gen i_audio_clock_gen (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .audio_mclk(audio_mclk), .audio_sclk(audio_sclk), .sclk_fall(sclk_fall)
  );

  i2s_serializer i_i2s_serializer (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .sclk_fall(sclk_fall), .core_sound(core_sound),
    .audio_lrck(audio_lrck), .audio_dac(audio_dac)
  );

endmodule

`default_nettype wire

/* sim/pong_shell_props.sv */
//////////////////////////////////////////////////////////////////////
// pong shell properties
// blanking and single-cycle pulse rules on the top-level outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pong_shell_props (
  input logic                 clk_74a,
  input logic                 arst_n,
  input logic                 video_de,
  input logic                 video_hs,
  input logic                 video_vs,
  input logic                 coin_insert,
  input pong_shell_pkg::rgb_t video_rgb
);

  blank_outside_de: assert property (@(posedge clk_74a) disable iff (!arst_n)
    !video_de |-> (video_rgb == '0))
    else $error("video_rgb not black outside display enable");

  // strobes never last two cycles
  hs_single: assert property (@(posedge clk_74a) disable iff (!arst_n)
    video_hs |=> !video_hs)
    else $error("video_hs high for two cycles");

  vs_single: assert property (@(posedge clk_74a) disable iff (!arst_n)
    video_vs |=> !video_vs)
    else $error("video_vs high for two cycles");

  coin_single: assert property (@(posedge clk_74a) disable iff (!arst_n)
    coin_insert |=> !coin_insert)
    else $error("coin_insert high for two cycles");

endmodule

bind pong_shell_top pong_shell_props i_pong_shell_props (
  .clk_74a(clk_74a), .arst_n(arst_n),
  .video_de(video_de), .video_hs(video_hs), .video_vs(video_vs),
  .coin_insert(coin_insert), .video_rgb(video_rgb)
);

`default_nettype wire

/* sim/pong_shell_tb.sv */
//////////////////////////////////////////////////////////////////////
// pong shell testbench
// random stimulus against a cycle model of the settings, pad
// mapping, coin pulse, video cleanup and the i2s audio path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module pong_shell_tb;

  import pong_shell_pkg::*;

  // about 1600 cycles of pad and video tests, the 20000 cycle mclk
  // window, then eight lrck halves per sound level, near 33000 in all
  localparam int timeout_cycles = 40000;
  localparam int mclk_window    = 20000;

  logic         clk_74a;
  logic         arst_n;
  logic         bridge_wr;
  bridge_word_t bridge_addr;
  bridge_word_t bridge_wr_data;
  key_word_t    cont1_key;
  key_word_t    cont2_key;
  logic         core_de;
  logic         core_hs;
  logic         core_vs;
  rgb_t         core_rgb;
  logic         core_sound;
  logic         score_stop_at_15;
  logic         disable_p2_on_pad_1;
  logic         prevent_coin_reset;
  logic         double_paddle_height;
  logic         training_mode;
  logic         p1_up;
  logic         p1_down;
  logic         p1_fine;
  logic         p2_up;
  logic         p2_down;
  logic         p2_fine;
  logic         coin_insert;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;
  rgb_t         video_rgb;
  logic         audio_mclk;
  logic         audio_sclk;
  logic         audio_lrck;
  logic         audio_dac;

  int error_count;
  int cycle_count;
  int errors_before;

  // model state, bit 0 of m_set is score stop, bit 4 training
  logic [4:0] m_set;
  logic       m_start_prev;
  logic       m_coin;
  logic       m_de1;
  logic       m_de2;
  rgb_t       m_rgb1;
  rgb_t       m_rgb2;
  logic       m_hs_prev;
  logic       m_hs_fall;
  logic       m_hs;
  logic       m_vs_prev;
  logic       m_vs_fall;
  logic       m_vs;
  int         start_rises;
  int         coin_pulses;

  // audio observation
  logic mclk_q;
  logic sclk_q;
  logic lrck_q;
  int   run_cycles;
  int   mclk_toggles;
  int   mclk_window_count;
  logic mclk_window_done;
  int   rises_in_half;
  int   ones_in_half;
  int   half_lens[$];
  int   half_ones[$];

  pong_shell_top i_pong_shell_top (
    .clk_74a(clk_74a), .arst_n(arst_n),
    .bridge_wr(bridge_wr), .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
    .cont1_key(cont1_key), .cont2_key(cont2_key),
    .core_de(core_de), .core_hs(core_hs), .core_vs(core_vs), .core_rgb(core_rgb),
    .core_sound(core_sound),
    .score_stop_at_15(score_stop_at_15), .disable_p2_on_pad_1(disable_p2_on_pad_1),
    .prevent_coin_reset(prevent_coin_reset), .double_paddle_height(double_paddle_height),
    .training_mode(training_mode),
    .p1_up(p1_up), .p1_down(p1_down), .p1_fine(p1_fine),
    .p2_up(p2_up), .p2_down(p2_down), .p2_fine(p2_fine),
    .coin_insert(coin_insert),
    .video_de(video_de), .video_hs(video_hs), .video_vs(video_vs), .video_rgb(video_rgb),
    .audio_mclk(audio_mclk), .audio_sclk(audio_sclk),
    .audio_lrck(audio_lrck), .audio_dac(audio_dac)
  );

  always #20 clk_74a = ~clk_74a;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d errors", name, error_count - errors_before);
    errors_before = error_count;
  endtask

  function automatic bridge_word_t pick_address();
    int sel;
    sel = int'($urandom_range(0, 8));
    case (sel)
      0: return 32'h0000_0000;
      1: return 32'h0000_0004;
      2: return 32'h0000_0008;
      3: return 32'h0000_000C;
      4: return 32'h0000_0010;
      5: return 32'h0000_0014;
      6: return 32'h0000_0018;
      7: return 32'h0000_001C;
      default: return $urandom;
    endcase
  endfunction

  function automatic logic [5:0] expected_paddles();
    logic pad_only;
    pad_only = m_set[1];
    // pad 1 X, B and R1 help player 2 unless pad 2 has sole control
    return {cont1_key[0], cont1_key[1], cont1_key[8],
            cont2_key[0] | (~pad_only & cont1_key[6]),
            cont2_key[1] | (~pad_only & cont1_key[5]),
            cont2_key[8] | (~pad_only & cont1_key[9])};
  endfunction

  task automatic check_settings(input logic [4:0] exp);
    check_value("score_stop_at_15", 32'(score_stop_at_15), 32'(exp[0]));
    check_value("disable_p2_on_pad_1", 32'(disable_p2_on_pad_1), 32'(exp[1]));
    check_value("prevent_coin_reset", 32'(prevent_coin_reset), 32'(exp[2]));
    check_value("double_paddle_height", 32'(double_paddle_height), 32'(exp[3]));
    check_value("training_mode", 32'(training_mode), 32'(exp[4]));
  endtask

  task automatic check_paddles();
    logic [5:0] exp;
    exp = expected_paddles();
    check_value("p1_up", 32'(p1_up), 32'(exp[5]));
    check_value("p1_down", 32'(p1_down), 32'(exp[4]));
    check_value("p1_fine", 32'(p1_fine), 32'(exp[3]));
    check_value("p2_up", 32'(p2_up), 32'(exp[2]));
    check_value("p2_down", 32'(p2_down), 32'(exp[1]));
    check_value("p2_fine", 32'(p2_fine), 32'(exp[0]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // model, steps on the same edges as the DUT

  always @(posedge clk_74a or negedge arst_n)
  begin
    if (!arst_n)
    begin
      m_set        <= 5'b00100;
      m_start_prev <= 1'b0;
      m_coin       <= 1'b0;
      m_de1        <= 1'b0;
      m_de2        <= 1'b0;
      m_rgb1       <= '0;
      m_rgb2       <= '0;
      m_hs_prev    <= 1'b0;
      m_hs_fall    <= 1'b0;
      m_hs         <= 1'b0;
      m_vs_prev    <= 1'b0;
      m_vs_fall    <= 1'b0;
      m_vs         <= 1'b0;
    end
    else
    begin
      if (bridge_wr)
      begin
        case (bridge_addr)
          32'h0000_0000: m_set[0] <= bridge_wr_data[0];
          32'h0000_0008: m_set[1] <= bridge_wr_data[0];
          32'h0000_000C: m_set[2] <= bridge_wr_data[0];
          32'h0000_0014: m_set[3] <= bridge_wr_data[0];
          32'h0000_0018: m_set[4] <= bridge_wr_data[0];
          default:
          begin
          end
        endcase
      end
      if (cont1_key[15] && !m_start_prev)
      begin
        start_rises <= start_rises + 1;
      end
      m_start_prev <= cont1_key[15];
      m_coin       <= cont1_key[15] & ~m_start_prev;
      // two cycles of latency
      m_de1  <= core_de;
      m_de2  <= m_de1;
      m_rgb1 <= core_rgb;
      m_rgb2 <= m_rgb1;
      // falling sync seen on one edge, pulse out on the next
      m_hs_prev <= core_hs;
      m_hs_fall <= m_hs_prev & ~core_hs;
      m_hs      <= m_hs_fall;
      m_vs_prev <= core_vs;
      m_vs_fall <= m_vs_prev & ~core_vs;
      m_vs      <= m_vs_fall;
    end
  end

  // outputs are stable on the falling edge
  always @(negedge clk_74a)
  begin
    if (arst_n)
    begin
      check_settings(m_set);
      check_paddles();
      check_value("coin_insert", 32'(coin_insert), 32'(m_coin));
      check_value("video_de", 32'(video_de), 32'(m_de2));
      // black whenever the delayed enable is low
      check_value("video_rgb", 32'(video_rgb), 32'(m_de2 ? m_rgb2 : 24'h0));
      check_value("video_hs", 32'(video_hs), 32'(m_hs));
      check_value("video_vs", 32'(video_vs), 32'(m_vs));
      if (coin_insert)
      begin
        coin_pulses++;
      end
    end
  end

  // audio monitor, counts toggles and decodes dac on rising sclk
  always @(negedge clk_74a)
  begin
    if (arst_n)
    begin
      if (audio_mclk !== mclk_q)
      begin
        mclk_toggles++;
      end
      if (run_cycles == mclk_window)
      begin
        mclk_window_count = mclk_toggles;
        mclk_window_done  = 1'b1;
      end
      if (audio_lrck !== lrck_q)
      begin
        half_lens.push_back(rises_in_half);
        half_ones.push_back(ones_in_half);
        rises_in_half = 0;
        ones_in_half  = 0;
      end
      if (audio_sclk && !sclk_q)
      begin
        rises_in_half++;
        if (audio_dac)
        begin
          ones_in_half++;
        end
      end
      mclk_q = audio_mclk;
      sclk_q = audio_sclk;
      lrck_q = audio_lrck;
      run_cycles++;
    end
  end

  always @(posedge clk_74a)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
    begin
      $display("timeout, run stopped after %0d cycles", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests

  task automatic drive_bridge_writes(input int n);
    repeat (n)
    begin
      @(posedge clk_74a);
      bridge_wr      <= 1'($urandom);
      bridge_addr    <= pick_address();
      bridge_wr_data <= $urandom;
    end
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  task automatic drive_pads(input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk_74a);
      cont1_key <= 16'($urandom);
      cont2_key <= 16'($urandom);
      // pad sharing on for the first half, pad 2 only for the second
      bridge_wr      <= (i == 0) || (i == n / 2);
      bridge_addr    <= 32'h0000_0008;
      bridge_wr_data <= (i == n / 2) ? 32'h1 : 32'h0;
    end
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  task automatic drive_start_button(input int n);
    logic      start_level;
    key_word_t pad;
    start_level = 1'b0;
    repeat (n)
    begin
      @(posedge clk_74a);
      if ($urandom_range(0, 3) == 0)
      begin
        start_level = ~start_level;
      end
      pad       = 16'($urandom);
      pad[15]   = start_level;
      cont1_key <= pad;
    end
    @(posedge clk_74a);
    cont1_key <= '0;
    repeat (4) @(posedge clk_74a);
    check_value("coin_insert pulses", 32'(coin_pulses), 32'(start_rises));
  endtask

  task automatic drive_video(input int n);
    repeat (n)
    begin
      @(posedge clk_74a);
      core_de  <= 1'($urandom);
      core_rgb <= 24'($urandom);
      if ($urandom_range(0, 7) == 0)
      begin
        core_hs <= ~core_hs;
      end
      if ($urandom_range(0, 15) == 0)
      begin
        core_vs <= ~core_vs;
      end
    end
    @(posedge clk_74a);
    core_de <= 1'b0;
    core_hs <= 1'b0;
    core_vs <= 1'b0;
    repeat (4) @(posedge clk_74a);
  endtask

  task automatic check_audio_clocks();
    longint scaled;
    longint target;
    while (!mclk_window_done) @(posedge clk_74a);
    scaled = longint'(mclk_window_count) * 742500;
    target = longint'(mclk_window) * 245760;
    assert ((scaled - target <= 742500) && (target - scaled <= 742500))
    else
    begin
      $display("Error: audio_mclk toggles got %h expected %h", mclk_window_count,
               int'(target / 742500));
      error_count++;
    end
    assert (half_lens.size() >= 10)
    else
    begin
      $display("audio_lrck changed only %0d times in the window", half_lens.size());
      error_count++;
    end
    // first half starts at reset, not at an lrck edge
    for (int i = 1; i < half_lens.size(); i++)
    begin
      check_value("audio_sclk rises per audio_lrck half", 32'(half_lens[i]), 32'd32);
    end
  endtask

  task automatic check_sound(input logic level);
    int first;
    int expected;
    expected = level ? $countones(16'h7000) : 0;
    @(posedge clk_74a);
    core_sound <= level;
    first = half_ones.size();
    while (half_ones.size() < first + 8) @(posedge clk_74a);
    // two frames to settle, then two frames decoded
    for (int i = first + 4; i < first + 8; i++)
    begin
      check_value("audio_dac ones per half", 32'(half_ones[i]), 32'(expected));
    end
  endtask

  initial
  begin
    void'($urandom(32'h13260ae0));
    clk_74a = 1'b0;
    arst_n = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    cont1_key = '0;
    cont2_key = '0;
    core_de = 1'b0;
    core_hs = 1'b0;
    core_vs = 1'b0;
    core_rgb = '0;
    core_sound = 1'b0;
    mclk_q = 1'b0;
    sclk_q = 1'b0;
    lrck_q = 1'b0;
    mclk_window_done = 1'b0;
    repeat (16) @(posedge clk_74a);
    arst_n <= 1'b1;
    @(negedge clk_74a);
    check_settings(5'b00100);

    drive_bridge_writes(300);
    report_test("bridge settings");
    drive_pads(300);
    report_test("paddle mapping");
    drive_start_button(400);
    report_test("coin pulse");
    drive_video(600);
    report_test("video cleanup");
    check_audio_clocks();
    report_test("audio clocks");
    check_sound(1'b1);
    check_sound(1'b0);
    report_test("audio data");

    $display("tests run: 6, errors: %0d", error_count);
    if (error_count == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pong_shell.f */
source/pong_shell_pkg.sv
source/bridge_settings.sv
source/player_input_map.sv
source/video_cleanup.sv
source/audio_clock_gen.sv
source/i2s_serializer.sv
source/pong_shell_top.sv
sim/pong_shell_props.sv
sim/pong_shell_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the pong shell testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module pong_shell_tb -f pong_shell.f -o pong_shell_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/pong_shell_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "simulation reported failures"
exit 1
